// ==== Bender.yml ====
package:
  name: cnn_feature

sources:
  - common/cnn_pkg.sv
  - fmap_feeder/fmap_feeder.sv
  - conv/conv_window.sv
  - conv/conv_mac.sv
  - source/result_accum.sv
  - source/cnn_apb_ctrl.sv
  - source/cnn_feature_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/cnn_feature_tb.sv

// ==== common/cnn_pkg.sv ====
package cnn_pkg;

    // image geometry
    localparam int IMG_W       = 8;
    localparam int IMG_H       = 8;
    localparam int NUM_IMAGES  = 4;
    localparam int IMG_PIXELS  = IMG_W * IMG_H;
    localparam int KERNEL_DIM  = 3;
    localparam int KERNEL_TAPS = KERNEL_DIM * KERNEL_DIM;
    // valid 3x3 positions per image, 6x6
    localparam int OUT_PIXELS  = (IMG_W - KERNEL_DIM + 1) * (IMG_H - KERNEL_DIM + 1);

    // data widths
    localparam int PIX_W      = 8;
    localparam int WGT_W      = 8;
    // unsigned pixel gets one extra bit before the signed multiply
    localparam int PROD_W     = PIX_W + 1 + WGT_W;
    localparam int ACC_W      = 20;
    localparam int SUM_W      = 32;
    localparam int COUNT_W    = 7;
    localparam int COL_W      = $clog2(IMG_W);
    localparam int ROW_W      = $clog2(IMG_H);
    localparam int IMG_SEL_W  = $clog2(NUM_IMAGES);
    localparam int PIX_ADDR_W = $clog2(NUM_IMAGES * IMG_PIXELS);
    localparam int FEED_CNT_W = $clog2(IMG_PIXELS) + 1;
    localparam int KIDX_W     = 4;

    // apb host port
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    // register map, byte offsets
    localparam logic [APB_ADDR_W-1:0] REG_CTRL        = 12'h000;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS      = 12'h004;
    localparam logic [APB_ADDR_W-1:0] REG_SUM         = 12'h008;
    localparam logic [APB_ADDR_W-1:0] REG_MAX         = 12'h00C;
    localparam logic [APB_ADDR_W-1:0] REG_COUNT       = 12'h010;
    localparam logic [APB_ADDR_W-1:0] REG_KERNEL_BASE = 12'h040;
    localparam logic [APB_ADDR_W-1:0] REG_KERNEL_END  = 12'h040 + 12'(4 * KERNEL_TAPS);
    localparam logic [APB_ADDR_W-1:0] REG_PIXEL_BASE  = 12'h400;
    localparam logic [APB_ADDR_W-1:0] REG_PIXEL_END   =
        12'h400 + 12'(4 * NUM_IMAGES * IMG_PIXELS);

    // register fields
    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_SEL_LSB    = 2;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // fsm encodings
    localparam logic [1:0] FEED_IDLE    = 2'd0;
    localparam logic [1:0] FEED_SENDING = 2'd1;
    localparam logic [1:0] FEED_DONE    = 2'd2;
    localparam logic       CTRL_IDLE    = 1'b0;
    localparam logic       CTRL_RUN     = 1'b1;

endpackage

// ==== conv/conv_mac.sv ====
module conv_mac
    import cnn_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         win_valid,
    input  logic [KERNEL_TAPS*PIX_W-1:0] window,
    input  logic [KERNEL_TAPS*WGT_W-1:0] kernel,
    output logic                         out_valid,
    output logic [ACC_W-1:0]             out_value
);

    logic signed [PROD_W-1:0] prod [0:KERNEL_TAPS-1];
    logic                     prod_valid;
    logic signed [ACC_W-1:0]  acc;

    // valid follows each window through both stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            out_valid  <= prod_valid;
        end
    end

    // stage one, pixel zero-extended so it stays positive
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int k = 0; k < KERNEL_TAPS; k++) begin
                prod[k] <= $signed({1'b0, window[k*PIX_W +: PIX_W]})
                           * $signed(kernel[k*WGT_W +: WGT_W]);
            end
        end
    end

    // adder tree, sign-extended products
    always_comb begin
        acc = '0;
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            acc = acc + ACC_W'(prod[k]);
        end
    end

    // stage two with relu
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            out_value <= acc[ACC_W-1] ? '0 : acc;
        end
    end

endmodule

// ==== conv/conv_window.sv ====
module conv_window
    import cnn_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic [PIX_W-1:0]             pixel,
    input  logic                         pix_valid,
    output logic                         win_valid,
    output logic [KERNEL_TAPS*PIX_W-1:0] window
);

    // line_a holds the previous row, line_b the row before it
    logic [PIX_W-1:0] line_a [0:IMG_W-1];
    logic [PIX_W-1:0] line_b [0:IMG_W-1];
    logic [PIX_W-1:0] win    [0:KERNEL_TAPS-1];
    logic [COL_W-1:0] col_cnt;
    logic [COL_W-1:0] cur_col;
    logic [ROW_W-1:0] row_cnt;
    logic [ROW_W-1:0] cur_row;
    logic             prev_valid;

    // a pixel after an idle gap starts a new image at (0,0)
    always_comb begin
        cur_col = prev_valid ? col_cnt : '0;
        cur_row = prev_valid ? row_cnt : '0;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prev_valid <= 1'b0;
            col_cnt    <= '0;
            row_cnt    <= '0;
            win_valid  <= 1'b0;
        end else begin
            prev_valid <= pix_valid;
            if (pix_valid) begin
                if (cur_col == COL_W'(IMG_W - 1)) begin
                    col_cnt <= '0;
                    row_cnt <= (cur_row == ROW_W'(IMG_H - 1)) ? '0 : cur_row + 1'b1;
                end else begin
                    col_cnt <= cur_col + 1'b1;
                    row_cnt <= cur_row;
                end
            end
            // only windows fully inside the image
            win_valid <= pix_valid && (cur_row >= ROW_W'(KERNEL_DIM - 1))
                         && (cur_col >= COL_W'(KERNEL_DIM - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            line_b[cur_col] <= line_a[cur_col];
            line_a[cur_col] <= pixel;
            // shift each window row one column left
            for (int r = 0; r < KERNEL_DIM; r++) begin
                for (int c = 0; c < KERNEL_DIM - 1; c++) begin
                    win[r*KERNEL_DIM + c] <= win[r*KERNEL_DIM + c + 1];
                end
            end
            // new right column, oldest row on top
            win[KERNEL_DIM - 1]     <= line_b[cur_col];
            win[2*KERNEL_DIM - 1]   <= line_a[cur_col];
            win[KERNEL_TAPS - 1]    <= pixel;
        end
    end

    always_comb begin
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            window[k*PIX_W +: PIX_W] = win[k];
        end
    end

endmodule

// ==== files.f ====
+incdir+verif
common/cnn_pkg.sv
fmap_feeder/fmap_feeder.sv
conv/conv_window.sv
conv/conv_mac.sv
source/result_accum.sv
source/cnn_apb_ctrl.sv
source/cnn_feature_top.sv
verif/cnn_feature_tb.sv

// ==== fmap_feeder/fmap_feeder.sv ====
module fmap_feeder
    import cnn_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    input  logic [IMG_SEL_W-1:0]  img_sel,
    input  logic                  pix_we,
    input  logic [PIX_ADDR_W-1:0] pix_addr,
    input  logic [PIX_W-1:0]      pix_data,
    output logic [PIX_W-1:0]      pixel,
    output logic                  pix_valid,
    output logic                  stream_done
);

    // four images back to back, image index in the upper address bits
    logic [PIX_W-1:0]      store [0:NUM_IMAGES*IMG_PIXELS-1];
    logic [PIX_W-1:0]      selected_pixel;
    logic [1:0]            state;
    logic [1:0]            state_next;
    logic [FEED_CNT_W-1:0] addr_reg;
    logic [FEED_CNT_W-1:0] addr_next;
    logic                  valid_next;
    logic                  done_next;
    logic                  load_pixel;

    // host write port
    always_ff @(posedge clk) begin
        if (pix_we) begin
            store[pix_addr] <= pix_data;
        end
    end

    assign selected_pixel = store[{img_sel, addr_reg[FEED_CNT_W-2:0]}];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= FEED_IDLE;
            addr_reg    <= '0;
            pix_valid   <= 1'b0;
            stream_done <= 1'b0;
        end else begin
            state       <= state_next;
            addr_reg    <= addr_next;
            pix_valid   <= valid_next;
            stream_done <= done_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_pixel) begin
            pixel <= selected_pixel;
        end
    end

    always_comb begin
        state_next = state;
        addr_next  = addr_reg;
        valid_next = 1'b0;
        done_next  = 1'b0;
        load_pixel = 1'b0;
        case (state)
            FEED_IDLE: begin
                if (start) begin
                    state_next = FEED_SENDING;
                end
            end
            FEED_SENDING: begin
                if (addr_reg < FEED_CNT_W'(IMG_PIXELS)) begin
                    load_pixel = 1'b1;
                    valid_next = 1'b1;
                    addr_next  = addr_reg + 1'b1;
                end else begin
                    // whole image sent
                    addr_next  = '0;
                    done_next  = 1'b1;
                    state_next = FEED_DONE;
                end
            end
            FEED_DONE: begin
                state_next = FEED_IDLE;
            end
            default: begin
                state_next = FEED_IDLE;
            end
        endcase
    end

endmodule

// ==== source/cnn_apb_ctrl.sv ====
module cnn_apb_ctrl
    import cnn_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [APB_ADDR_W-1:0]        paddr,
    input  logic [APB_DATA_W-1:0]        pwdata,
    input  logic [SUM_W-1:0]             sum,
    input  logic [ACC_W-1:0]             max,
    input  logic [COUNT_W-1:0]           count,
    output logic [APB_DATA_W-1:0]        prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         start,
    output logic [IMG_SEL_W-1:0]         img_sel,
    output logic [KERNEL_TAPS*WGT_W-1:0] kernel,
    output logic                         pix_we,
    output logic [PIX_ADDR_W-1:0]        pix_addr,
    output logic [PIX_W-1:0]             pix_data
);

    logic                  access;
    logic                  wr_access;
    logic                  hit_ctrl;
    logic                  hit_status;
    logic                  hit_sum;
    logic                  hit_max;
    logic                  hit_count;
    logic                  hit_kern;
    logic                  hit_pix;
    logic                  unmapped;
    logic [APB_ADDR_W-1:0] kern_off;
    logic [APB_ADDR_W-1:0] pix_off;
    logic [KIDX_W-1:0]     kern_idx;
    logic [WGT_W-1:0]      kern_q [0:KERNEL_TAPS-1];
    logic                  state;
    logic                  done;
    logic                  busy;
    logic                  start_req;
    logic                  kern_we;
    logic                  pix_req;

    assign pready = 1'b1;

    // address decode for the access cycle
    always_comb begin
        access     = psel & penable;
        wr_access  = access & pwrite;
        hit_ctrl   = (paddr == REG_CTRL);
        hit_status = (paddr == REG_STATUS);
        hit_sum    = (paddr == REG_SUM);
        hit_max    = (paddr == REG_MAX);
        hit_count  = (paddr == REG_COUNT);
        hit_kern   = (paddr >= REG_KERNEL_BASE) && (paddr < REG_KERNEL_END)
                     && (paddr[1:0] == 2'b00);
        hit_pix    = (paddr >= REG_PIXEL_BASE) && (paddr < REG_PIXEL_END)
                     && (paddr[1:0] == 2'b00);
        unmapped   = ~(hit_ctrl | hit_status | hit_sum | hit_max | hit_count
                       | hit_kern | hit_pix);
        kern_off   = paddr - REG_KERNEL_BASE;
        pix_off    = paddr - REG_PIXEL_BASE;
        kern_idx   = kern_off[KIDX_W+1:2];
    end

    // busy already covers the start pulse cycle
    always_comb begin
        busy      = (state == CTRL_RUN) | start;
        start_req = wr_access & hit_ctrl & pwdata[CTRL_START_BIT];
        kern_we   = wr_access & hit_kern & ~busy;
        pix_req   = wr_access & hit_pix & ~busy;
        pslverr   = access & (unmapped
                    | (busy & ((wr_access & (hit_kern | hit_pix)) | start_req)));
    end

    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[CTRL_SEL_LSB +: IMG_SEL_W] = img_sel;
        end else if (hit_status) begin
            prdata[STATUS_BUSY_BIT] = busy;
            prdata[STATUS_DONE_BIT] = done;
        end else if (hit_sum) begin
            prdata = APB_DATA_W'(sum);
        end else if (hit_max) begin
            prdata = APB_DATA_W'(max);
        end else if (hit_count) begin
            prdata = APB_DATA_W'(count);
        end else if (hit_kern) begin
            // weights read back sign-extended
            prdata = APB_DATA_W'($signed(kern_q[kern_idx]));
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start   <= 1'b0;
            img_sel <= '0;
            pix_we  <= 1'b0;
            state   <= CTRL_IDLE;
            done    <= 1'b0;
            for (int k = 0; k < KERNEL_TAPS; k++) begin
                kern_q[k] <= '0;
            end
        end else begin
            start  <= start_req & ~busy;
            pix_we <= pix_req;
            if (start_req & ~busy) begin
                img_sel <= pwdata[CTRL_SEL_LSB +: IMG_SEL_W];
            end
            if (kern_we) begin
                kern_q[kern_idx] <= pwdata[WGT_W-1:0];
            end
            case (state)
                CTRL_IDLE: begin
                    if (start) begin
                        state <= CTRL_RUN;
                        done  <= 1'b0;
                    end
                end
                default: begin
                    // all outputs accumulated
                    if (count == COUNT_W'(OUT_PIXELS)) begin
                        state <= CTRL_IDLE;
                        done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pix_req) begin
            pix_addr <= pix_off[PIX_ADDR_W+1:2];
            pix_data <= pwdata[PIX_W-1:0];
        end
    end

    always_comb begin
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            kernel[k*WGT_W +: WGT_W] = kern_q[k];
        end
    end

endmodule

// ==== source/cnn_feature_top.sv ====
module cnn_feature_top
    import cnn_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic                         start;
    logic [IMG_SEL_W-1:0]         img_sel;
    logic [KERNEL_TAPS*WGT_W-1:0] kernel;
    logic                         pix_we;
    logic [PIX_ADDR_W-1:0]        pix_addr;
    logic [PIX_W-1:0]             pix_data;
    logic [PIX_W-1:0]             pixel;
    logic                         pix_valid;
    logic                         win_valid;
    logic [KERNEL_TAPS*PIX_W-1:0] window;
    logic                         out_valid;
    logic [ACC_W-1:0]             out_value;
    logic [SUM_W-1:0]             sum;
    logic [ACC_W-1:0]             max;
    logic [COUNT_W-1:0]           count;

    cnn_apb_ctrl cnn_apb_ctrl_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .sum      (sum),
        .max      (max),
        .count    (count),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .start    (start),
        .img_sel  (img_sel),
        .kernel   (kernel),
        .pix_we   (pix_we),
        .pix_addr (pix_addr),
        .pix_data (pix_data)
    );

    // run end is taken from the result count, not the stream
    fmap_feeder fmap_feeder_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .img_sel     (img_sel),
        .pix_we      (pix_we),
        .pix_addr    (pix_addr),
        .pix_data    (pix_data),
        .pixel       (pixel),
        .pix_valid   (pix_valid),
        .stream_done ()
    );

    conv_window conv_window_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .pixel     (pixel),
        .pix_valid (pix_valid),
        .win_valid (win_valid),
        .window    (window)
    );

    conv_mac conv_mac_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .win_valid (win_valid),
        .window    (window),
        .kernel    (kernel),
        .out_valid (out_valid),
        .out_value (out_value)
    );

    result_accum result_accum_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .clear     (start),
        .out_valid (out_valid),
        .out_value (out_value),
        .sum       (sum),
        .max       (max),
        .count     (count)
    );

endmodule

// ==== source/result_accum.sv ====
module result_accum
    import cnn_pkg::*;
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic               clear,
    input  logic               out_valid,
    input  logic [ACC_W-1:0]   out_value,
    output logic [SUM_W-1:0]   sum,
    output logic [ACC_W-1:0]   max,
    output logic [COUNT_W-1:0] count
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum   <= '0;
            max   <= '0;
            count <= '0;
        end else if (clear) begin
            // new run
            sum   <= '0;
            max   <= '0;
            count <= '0;
        end else if (out_valid) begin
            sum   <= sum + SUM_W'(out_value);
            count <= count + 1'b1;
            if (out_value > max) begin
                max <= out_value;
            end
        end
    end

endmodule

// ==== verif/cnn_apb_tasks.svh ====
// every transfer starts 1 ns after a rising edge and returns at the same point
task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // sample mid access cycle
    @(negedge clk);
    err = pslverr;
    check_value("pready", 32'(pready), 32'h1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check_value("pready", 32'(pready), 32'h1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic write_checked(input logic [11:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_value("pslverr", 32'(err), 32'h0);
endtask

task automatic read_and_compare(input string name, input logic [11:0] addr,
                                input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_value("pslverr", 32'(err), 32'h0);
    check_value(name, data, exp);
endtask

task automatic load_images();
    for (int i = 0; i < NUM_IMAGES; i++) begin
        for (int p = 0; p < IMG_PIXELS; p++) begin
            img[i][p] = 8'($random(seed));
            write_checked(REG_PIXEL_BASE + 12'(4 * (i*IMG_PIXELS + p)), 32'(img[i][p]));
        end
    end
endtask

task automatic write_kernel();
    for (int k = 0; k < KERNEL_TAPS; k++) begin
        write_checked(REG_KERNEL_BASE + 12'(4 * k), {{24{kern[k][7]}}, kern[k]});
    end
endtask

task automatic wait_for_done();
    logic [31:0] status;
    logic        err;
    // done set and busy clear, bounded by the global timeout
    do begin
        apb_read(REG_STATUS, status, err);
        check_value("pslverr", 32'(err), 32'h0);
    end while (status[1] !== 1'b1 || status[0] !== 1'b0);
endtask

task automatic compare_results(input int sel);
    int exp_sum;
    int exp_max;
    int exp_count;
    compute_expected(sel, exp_sum, exp_max, exp_count);
    read_and_compare("sum", REG_SUM, 32'(exp_sum));
    read_and_compare("max", REG_MAX, 32'(exp_max));
    read_and_compare("count", REG_COUNT, 32'(exp_count));
endtask

task automatic run_image(input int sel);
    write_checked(REG_CTRL, (32'(sel) << 2) | 32'h1);
    wait_for_done();
    compare_results(sel);
endtask

task automatic check_reset_values();
    read_and_compare("status", REG_STATUS, 32'h0);
    read_and_compare("sum", REG_SUM, 32'h0);
    read_and_compare("max", REG_MAX, 32'h0);
    read_and_compare("count", REG_COUNT, 32'h0);
endtask

task automatic check_identity_run();
    load_images();
    for (int k = 0; k < KERNEL_TAPS; k++) begin
        kern[k] = (k == 4) ? 8'sd1 : 8'sd0;
    end
    write_kernel();
    run_image(2);
endtask

task automatic check_image_select();
    for (int k = 0; k < KERNEL_TAPS; k++) begin
        kern[k] = 8'($random(seed));
    end
    write_kernel();
    for (int i = 0; i < NUM_IMAGES; i++) begin
        run_image(i);
    end
endtask

task automatic check_relu_clamp();
    logic [31:0] r;
    for (int k = 0; k < KERNEL_TAPS; k++) begin
        r = $random(seed);
        // sign bit forced, so every weight is negative
        kern[k] = {1'b1, r[6:0]};
    end
    write_kernel();
    write_checked(REG_CTRL, 32'h1);
    wait_for_done();
    read_and_compare("sum", REG_SUM, 32'h0);
    read_and_compare("max", REG_MAX, 32'h0);
    read_and_compare("count", REG_COUNT, 32'(OUT_PIXELS));
endtask

task automatic check_busy_protect();
    logic err;
    for (int k = 0; k < KERNEL_TAPS; k++) begin
        kern[k] = 8'($random(seed));
    end
    write_kernel();
    write_checked(REG_CTRL, (32'd1 << 2) | 32'h1);
    apb_write(REG_KERNEL_BASE + 12'h10, 32'h55, err);
    assert (err === 1'b1) else begin
        stop_on_error("kernel write while busy was accepted without an error");
    end
    apb_write(REG_CTRL, (32'd3 << 2) | 32'h1, err);
    assert (err === 1'b1) else begin
        stop_on_error("second start while busy was accepted without an error");
    end
    wait_for_done();
    compare_results(1);
endtask

task automatic check_unmapped_and_readback();
    logic [31:0] data;
    logic        err;
    apb_read(12'h020, data, err);
    assert (err === 1'b1) else begin
        stop_on_error("read of an unmapped address gave no error");
    end
    kern[7] = 8'sh9c;
    write_checked(REG_KERNEL_BASE + 12'h1c, 32'hffffff9c);
    read_and_compare("kernel[7]", REG_KERNEL_BASE + 12'h1c, 32'hffffff9c);
endtask

// ==== verif/cnn_feature_tb.sv ====
module cnn_feature_tb
    import cnn_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20000;

    logic                  clk;
    logic                  reset_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // testbench copies of the loaded images and the current kernel
    logic [PIX_W-1:0]        img [NUM_IMAGES][IMG_PIXELS];
    logic signed [WGT_W-1:0] kern [KERNEL_TAPS];
    integer                  seed;
    int                      cycle_count;

    cnn_feature_top cnn_feature_top_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("TEST FAILED");
        $display("%s", msg);
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_on_error($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // one 3x3 output, signed weights times unsigned pixels, then relu
    function automatic int window_result(input int sel, input int r, input int c);
        int acc;
        int w;
        int p;
        acc = 0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                w = kern[i*3 + j];
                p = img[sel][(r + i)*IMG_W + c + j];
                acc = acc + w * p;
            end
        end
        if (acc < 0) begin
            acc = 0;
        end
        return acc;
    endfunction

    task automatic compute_expected(input int sel, output int exp_sum, output int exp_max,
                                    output int exp_count);
        int v;
        exp_sum   = 0;
        exp_max   = 0;
        exp_count = 0;
        for (int r = 0; r <= IMG_H - 3; r++) begin
            for (int c = 0; c <= IMG_W - 3; c++) begin
                v = window_result(sel, r, c);
                exp_sum = exp_sum + v;
                if (v > exp_max) begin
                    exp_max = v;
                end
                exp_count++;
            end
        end
    endtask

`include "cnn_apb_tasks.svh"

    // run limit, well above the length of all tests together
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        stop_on_error("timeout, the tests did not finish within the cycle limit");
    end

    initial begin
        seed    = 32'h967a1863;
        reset_n = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        check_reset_values();
        check_identity_run();
        check_image_select();
        check_relu_clamp();
        check_busy_protect();
        check_unmapped_and_readback();
        $display("TEST OK");
        $finish;
    end

endmodule
